//--- Makefile
VERILATOR ?= verilator
TOP       ?= wasm_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
source/wasm_pkg.sv
source/program_rom.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/operand_stack.sv
source/wasm_core.sv
dv/wasm_core_tb.sv

//--- dv/wasm_core_tb.sv
`timescale 1ns/1ps

module wasm_core_tb import wasm_pkg::*; ();

  localparam int ROM_ADDR     = 8;
  localparam int STACK_DEPTH  = 4;
  localparam int MAX_ENTRIES  = 2 ** STACK_DEPTH;
  localparam int TRAP_TIMEOUT = 600;

  logic                clk;
  logic                reset;
  logic                run;
  logic                prog_we;
  logic [ROM_ADDR-1:0] prog_addr;
  logic [7:0]          prog_data;
  logic [VALUE_W-1:0]  result;
  val_type_t           result_type;
  logic                result_empty;
  trap_e               trap;

  int          value_errors;
  int          protocol_errors;
  int          timeout_errors;
  logic [31:0] lfsr_state;

  // Program image and reference stack, top at the back
  logic [7:0]         prog_q[$];
  logic [VALUE_W-1:0] model_val[$];
  val_type_t          model_type[$];
  trap_e              model_trap;

  wasm_core #(.ROM_ADDR(ROM_ADDR), .STACK_DEPTH(STACK_DEPTH)) wasm_core_i (
    .clk(clk), .reset(reset), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .result(result), .result_type(result_type),
    .result_empty(result_empty), .trap(trap)
  );

  always #2 clk = ~clk;

  a_four_cycle_instr: assert property (@(posedge clk) disable iff (reset)
    wasm_core_i.exec_done |-> $past(wasm_core_i.issue, 4))
    else begin
      $display("An instruction finished without an issue four cycles before it");
      protocol_errors++;
    end

  a_trap_holds: assert property (@(posedge clk) disable iff (reset)
    $past(trap) != TRAP_NONE |-> trap == $past(trap))
    else begin
      $display("The trap code changed before reset, now %0d", trap);
      protocol_errors++;
    end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic next_random_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_random_bit()};
    end
    return v;
  endfunction

  // Signed LEB128, stop once the rest is pure sign
  task automatic emit_leb(input logic signed [63:0] value);
    logic [7:0] b;
    logic       done;
    done = 1'b0;
    while (!done) begin
      b     = {1'b0, value[6:0]};
      value = value >>> 7;
      done  = (value == '0 && !b[6]) || (value == '1 && b[6]);
      if (!done) begin
        b[7] = 1'b1;
      end
      prog_q.push_back(b);
    end
  endtask

  function automatic logic [63:0] fit(input val_type_t t, input logic [63:0] v);
    return (t == TYPE_I32) ? {32'b0, v[31:0]} : v;
  endfunction

  task automatic model_pop(input int count);
    for (int i = 0; i < count; i++) begin
      void'(model_val.pop_back());
      void'(model_type.pop_back());
    end
  endtask

  task automatic model_push(input val_type_t t, input logic [63:0] v);
    model_type.push_back(t);
    model_val.push_back(fit(t, v));
  endtask

  // Reference rules for one instruction
  task automatic model_step(input logic [7:0] op, input logic [63:0] immv);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    val_type_t   want;
    val_type_t   rt;
    int          n;
    if (model_trap != TRAP_NONE) return;
    n    = model_val.size();
    want = (op inside {OP_I64_EQZ, OP_I64_EQ, OP_I64_NE, OP_I64_ADD, OP_I64_SUB}) ?
           TYPE_I64 : TYPE_I32;
    case (op)
      OP_UNREACHABLE: model_trap = TRAP_UNREACHABLE;
      OP_NOP: ;
      OP_END: model_trap = TRAP_ENDED;
      OP_DROP: begin
        if (n == 0) model_trap = TRAP_STACK_EMPTY;
        else        model_pop(1);
      end
      OP_SELECT: begin
        if (n < 3)                                   model_trap = TRAP_STACK_EMPTY;
        else if (model_type[n-1] != TYPE_I32)        model_trap = TRAP_TYPE_MISMATCH;
        else if (model_type[n-2] != model_type[n-3]) model_trap = TRAP_TYPES_MISMATCH;
        else begin
          r  = (model_val[n-1][31:0] != 32'd0) ? model_val[n-2] : model_val[n-3];
          rt = model_type[n-2];
          model_pop(3);
          model_push(rt, r);
        end
      end
      OP_I32_CONST, OP_I64_CONST: begin
        if (n == MAX_ENTRIES)        model_trap = TRAP_STACK_ERROR;
        else if (op == OP_I32_CONST) model_push(TYPE_I32, immv);
        else                         model_push(TYPE_I64, immv);
      end
      OP_I32_EQZ, OP_I64_EQZ: begin
        if (n == 0)                       model_trap = TRAP_STACK_EMPTY;
        else if (model_type[n-1] != want) model_trap = TRAP_TYPE_MISMATCH;
        else begin
          r = 64'(model_val[n-1] == '0);
          model_pop(1);
          model_push(want, r);
        end
      end
      OP_I32_EQ, OP_I32_NE, OP_I32_ADD, OP_I32_SUB,
      OP_I64_EQ, OP_I64_NE, OP_I64_ADD, OP_I64_SUB: begin
        if (n < 2) model_trap = TRAP_STACK_EMPTY;
        else if (model_type[n-1] != want || model_type[n-2] != want)
          model_trap = TRAP_TYPE_MISMATCH;
        else begin
          a = model_val[n-2];
          b = model_val[n-1];
          case (op)
            OP_I32_EQ, OP_I64_EQ:   r = 64'(a == b);
            OP_I32_NE, OP_I64_NE:   r = 64'(a != b);
            OP_I32_ADD, OP_I64_ADD: r = a + b;
            default:                r = a - b;
          endcase
          model_pop(2);
          model_push(want, r);
        end
      end
      default: model_trap = TRAP_UNKNOWN_OPCODE;
    endcase
  endtask

  task automatic new_program();
    prog_q.delete();
    model_val.delete();
    model_type.delete();
    model_trap = TRAP_NONE;
  endtask

  task automatic add_const(input val_type_t t, input logic [63:0] v);
    logic [63:0] ext;
    ext = (t == TYPE_I32) ? {{32{v[31]}}, v[31:0]} : v;
    prog_q.push_back((t == TYPE_I32) ? OP_I32_CONST : OP_I64_CONST);
    emit_leb(ext);
    model_step((t == TYPE_I32) ? OP_I32_CONST : OP_I64_CONST, ext);
  endtask

  task automatic add_op(input logic [7:0] op);
    prog_q.push_back(op);
    model_step(op, '0);
  endtask

  task automatic check_outcome(input string name);
    int n;
    n = model_val.size();
    assert (trap == model_trap) else begin
      $display("[FAIL] %s trap expected %0d actual %0d", name, model_trap, trap);
      value_errors++;
    end
    assert (result_empty == (n == 0)) else begin
      $display("[FAIL] %s result_empty expected %0d actual %0d", name, n == 0, result_empty);
      value_errors++;
    end
    if (n > 0) begin
      assert (result == model_val[n-1]) else begin
        $display("[FAIL] %s result expected %h actual %h", name, model_val[n-1], result);
        value_errors++;
      end
      assert (result_type == model_type[n-1]) else begin
        $display("[FAIL] %s result_type expected %0d actual %0d", name,
                 model_type[n-1], result_type);
        value_errors++;
      end
    end
  endtask

  // Reset, load with run low, then run until the core traps
  task automatic run_program(input string name);
    int cycles;
    @(posedge clk);
    reset <= 1'b1;
    run   <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    foreach (prog_q[i]) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= ROM_ADDR'(i);
      prog_data <= prog_q[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    run     <= 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (trap == TRAP_NONE && cycles < TRAP_TIMEOUT);
    if (trap == TRAP_NONE) begin
      $display("Program %s did not stop within %0d cycles", name, TRAP_TIMEOUT);
      timeout_errors++;
    end else begin
      check_outcome(name);
    end
    @(posedge clk);
    run <= 1'b0;
  endtask

  initial begin
    logic [31:0] k;
    int          ops;
    clk             = 1'b0;
    reset           = 1'b1;
    run             = 1'b0;
    prog_we         = 1'b0;
    prog_addr       = '0;
    prog_data       = '0;
    value_errors    = 0;
    protocol_errors = 0;
    timeout_errors  = 0;
    lfsr_state      = 32'h7f6edfac;

    new_program();
    add_const(TYPE_I32, 64'd100);
    add_const(TYPE_I32, 64'd23);
    add_op(OP_I32_SUB);
    add_const(TYPE_I32, 64'hffff_fffb);
    add_op(OP_I32_ADD);
    add_const(TYPE_I32, 64'h7fff_ffff);
    add_op(OP_I32_ADD);
    add_const(TYPE_I32, 64'd3);
    add_op(OP_I32_SUB);
    add_op(OP_END);
    run_program("i32_arith");

    // Long and negative immediates
    new_program();
    add_const(TYPE_I64, 64'h0123_4567_89ab_cdef);
    add_const(TYPE_I64, -64'sd1000000);
    add_op(OP_I64_ADD);
    add_const(TYPE_I64, 64'h8000_0000_0000_0000);
    add_op(OP_I64_SUB);
    add_op(OP_END);
    run_program("i64_add_sub");

    new_program();
    add_const(TYPE_I64, 64'h7fff_ffff_ffff_ffff);
    add_const(TYPE_I64, 64'h7fff_ffff_ffff_ffff);
    add_op(OP_I64_EQ);
    add_const(TYPE_I64, -64'sd1);
    add_const(TYPE_I64, 64'h0000_0040_0000_0000);
    add_op(OP_I64_NE);
    add_op(OP_I64_ADD);
    add_op(OP_NOP);
    add_op(OP_I64_EQZ);
    add_op(OP_END);
    run_program("i64_compare");

    new_program();
    add_const(TYPE_I32, 64'd7);
    add_const(TYPE_I32, 64'd9);
    add_op(OP_DROP);
    add_op(OP_END);
    run_program("drop");

    for (int sel = 0; sel < 2; sel++) begin
      new_program();
      add_const(TYPE_I64, 64'h1111_2222_3333_4444);
      add_const(TYPE_I64, 64'hdead_0000_beef_0000);
      add_const(TYPE_I32, 64'(sel * 5));
      add_op(OP_SELECT);
      add_op(OP_END);
      run_program($sformatf("select_%0d", sel));
    end

    new_program();
    add_const(TYPE_I32, 64'd1);
    add_const(TYPE_I64, 64'd2);
    add_const(TYPE_I32, 64'd1);
    add_op(OP_SELECT);
    add_op(OP_END);
    run_program("select_mixed");

    new_program();
    add_const(TYPE_I32, 64'd5);
    add_const(TYPE_I64, 64'd6);
    add_op(OP_I32_ADD);
    add_op(OP_END);
    run_program("type_mismatch");

    new_program();
    add_const(TYPE_I32, 64'd3);
    add_op(OP_UNREACHABLE);
    add_op(OP_END);
    run_program("unreachable");

    new_program();
    add_const(TYPE_I32, 64'd3);
    add_op(8'hff);
    add_op(OP_END);
    run_program("unknown_opcode");

    new_program();
    add_op(OP_I32_EQZ);
    add_op(OP_END);
    run_program("empty_eqz");

    // One push more than the stack holds
    new_program();
    for (int i = 0; i <= MAX_ENTRIES; i++) begin
      add_const(TYPE_I32, 64'(i + 1));
    end
    add_op(OP_END);
    run_program("overflow");

    for (int round = 0; round < 8; round++) begin
      new_program();
      add_const(TYPE_I32, {32'b0, random_bits(32)});
      ops = 2 + int'(random_bits(3));
      for (int j = 0; j < ops; j++) begin
        add_const(TYPE_I32, {32'b0, random_bits(32)});
        k = random_bits(2);
        add_op((k == 0) ? OP_I32_EQ : (k[0] ? OP_I32_ADD : OP_I32_SUB));
      end
      add_op(OP_END);
      run_program($sformatf("random_%0d", round));
    end

    $display("Errors: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timeout_errors);
    if (value_errors + protocol_errors + timeout_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import wasm_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      issue,
  input  logic [WINDOW_BYTES*8-1:0] rom_window,
  output logic                      dec_valid,
  output opcode_e                   opcode,
  output logic [VALUE_W-1:0]        imm,
  output logic [LEN_W-1:0]          instr_len
);

  localparam int ACC_W = 7 * IMM_BYTES;

  logic             issue_d;
  opcode_e          cur_opcode;
  logic             has_imm;
  logic [7:0]       leb_byte;
  logic [ACC_W-1:0] leb_acc;
  logic             leb_sign;
  logic             leb_done;
  logic [LEN_W-1:0] leb_len;

  assign cur_opcode = opcode_e'(rom_window[WINDOW_BYTES*8-1 -: 8]);
  assign has_imm    = cur_opcode inside {OP_I32_CONST, OP_I64_CONST};

  // Signed LEB128, seven bits per byte up to the first byte with bit 7 clear
  always_comb begin
    leb_byte = '0;
    leb_acc  = '0;
    leb_sign = 1'b0;
    leb_done = 1'b0;
    leb_len  = '0;
    for (int i = 0; i < IMM_BYTES; i++) begin
      if (!leb_done) begin
        leb_byte           = rom_window[(WINDOW_BYTES-2-i)*8 +: 8];
        leb_acc[7*i +: 7]  = leb_byte[6:0];
        leb_sign           = leb_byte[6];
        leb_len            = LEN_W'(i + 1);
        leb_done           = !leb_byte[7];
      end
    end
    // Sign extend above the last group
    for (int j = 0; j < ACC_W; j++) begin
      if (j >= 7 * int'(leb_len)) begin
        leb_acc[j] = leb_sign;
      end
    end
  end

  // Window arrives one cycle after issue
  always_ff @(posedge clk) begin
    if (reset) begin
      issue_d   <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      issue_d   <= issue;
      dec_valid <= issue_d;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_d) begin
      opcode    <= cur_opcode;
      imm       <= has_imm ? leb_acc[VALUE_W-1:0] : '0;
      instr_len <= has_imm ? LEN_W'(1) + leb_len : LEN_W'(1);
    end
  end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import wasm_pkg::*; #(
  parameter int STACK_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 dec_valid,
  input  opcode_e              opcode,
  input  logic [VALUE_W-1:0]   imm,
  input  stack_entry_t         tos,
  input  stack_entry_t         nos,
  input  stack_entry_t         third,
  input  logic                 empty,
  input  logic [STACK_DEPTH:0] depth,
  input  logic                 overflow,
  output stack_op_e            stk_op,
  output stack_entry_t         stk_data,
  output logic                 exec_done,
  output trap_e                trap
);

  localparam logic [STACK_DEPTH:0] FULL = (STACK_DEPTH + 1)'(2 ** STACK_DEPTH);

  logic         is_i64;
  val_type_t    want_type;
  logic [31:0]  res32;
  logic [63:0]  res64;
  stack_op_e    nxt_op;
  stack_entry_t nxt_data;
  trap_e        nxt_trap;
  logic         act_d;

  // Sub and compares take nos as the left operand
  always_comb begin
    is_i64    = opcode inside {OP_I64_EQZ, OP_I64_EQ, OP_I64_NE, OP_I64_ADD, OP_I64_SUB};
    want_type = is_i64 ? TYPE_I64 : TYPE_I32;
    case (opcode)
      OP_I32_EQZ: res32 = {31'b0, tos.value.i32.lo == 32'd0};
      OP_I32_EQ:  res32 = {31'b0, nos.value.i32.lo == tos.value.i32.lo};
      OP_I32_NE:  res32 = {31'b0, nos.value.i32.lo != tos.value.i32.lo};
      OP_I32_ADD: res32 = nos.value.i32.lo + tos.value.i32.lo;
      OP_I32_SUB: res32 = nos.value.i32.lo - tos.value.i32.lo;
      default:    res32 = '0;
    endcase
    case (opcode)
      OP_I64_EQZ: res64 = {63'b0, tos.value.i64 == 64'd0};
      OP_I64_EQ:  res64 = {63'b0, nos.value.i64 == tos.value.i64};
      OP_I64_NE:  res64 = {63'b0, nos.value.i64 != tos.value.i64};
      OP_I64_ADD: res64 = nos.value.i64 + tos.value.i64;
      OP_I64_SUB: res64 = nos.value.i64 - tos.value.i64;
      default:    res64 = '0;
    endcase
  end

  // Operand checks and stack command
  always_comb begin
    nxt_op   = STK_NONE;
    nxt_trap = TRAP_NONE;
    nxt_data = '0;
    if (is_i64) begin
      nxt_data.vtype     = TYPE_I64;
      nxt_data.value.i64 = res64;
    end else begin
      nxt_data.vtype        = TYPE_I32;
      nxt_data.value.i32.lo = res32;
    end
    case (opcode)
      OP_UNREACHABLE: nxt_trap = TRAP_UNREACHABLE;
      OP_NOP:         nxt_op   = STK_NONE;
      OP_END:         nxt_trap = TRAP_ENDED;
      OP_DROP: begin
        if (empty) nxt_trap = TRAP_STACK_EMPTY;
        else       nxt_op   = STK_POP;
      end
      OP_SELECT: begin
        nxt_data = (tos.value.i32.lo != 32'd0) ? nos : third;
        if (depth < 3)                       nxt_trap = TRAP_STACK_EMPTY;
        else if (tos.vtype != TYPE_I32)      nxt_trap = TRAP_TYPE_MISMATCH;
        else if (nos.vtype != third.vtype)   nxt_trap = TRAP_TYPES_MISMATCH;
        else                                 nxt_op   = STK_POP3_PUSH;
      end
      OP_I32_CONST, OP_I64_CONST: begin
        nxt_data = '0;
        if (opcode == OP_I64_CONST) begin
          nxt_data.vtype     = TYPE_I64;
          nxt_data.value.i64 = imm;
        end else begin
          nxt_data.vtype        = TYPE_I32;
          nxt_data.value.i32.lo = imm[31:0];
        end
        // A full stack traps here instead of losing the push
        if (overflow || depth == FULL) nxt_trap = TRAP_STACK_ERROR;
        else                           nxt_op   = STK_PUSH;
      end
      OP_I32_EQZ, OP_I64_EQZ: begin
        if (empty)                        nxt_trap = TRAP_STACK_EMPTY;
        else if (tos.vtype != want_type)  nxt_trap = TRAP_TYPE_MISMATCH;
        else                              nxt_op   = STK_REPLACE;
      end
      OP_I32_EQ, OP_I32_NE, OP_I32_ADD, OP_I32_SUB,
      OP_I64_EQ, OP_I64_NE, OP_I64_ADD, OP_I64_SUB: begin
        if (depth < 2)                    nxt_trap = TRAP_STACK_EMPTY;
        else if (tos.vtype != want_type || nos.vtype != want_type)
                                          nxt_trap = TRAP_TYPE_MISMATCH;
        else                              nxt_op   = STK_POP2_PUSH;
      end
      default: nxt_trap = TRAP_UNKNOWN_OPCODE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stk_op    <= STK_NONE;
      act_d     <= 1'b0;
      exec_done <= 1'b0;
      trap      <= TRAP_NONE;
    end else begin
      act_d     <= dec_valid;
      exec_done <= act_d;
      stk_op    <= STK_NONE;
      // Trap is sticky until reset
      if (dec_valid && trap == TRAP_NONE) begin
        if (nxt_trap != TRAP_NONE) trap   <= nxt_trap;
        else                       stk_op <= nxt_op;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      stk_data <= nxt_data;
    end
  end

  // Only one instruction in flight around a stack command
  a_stk_op_isolated: assert property (@(posedge clk) disable iff (reset)
    stk_op != STK_NONE |-> !dec_valid && !exec_done);

endmodule

//--- source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import wasm_pkg::*; #(
  parameter int ROM_ADDR = 8
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic                dec_valid,
  input  logic [LEN_W-1:0]    instr_len,
  input  logic                exec_done,
  input  trap_e               trap,
  output logic [ROM_ADDR-1:0] rom_addr,
  output logic                issue
);

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_DECODE = 2'd1;
  localparam logic [1:0] S_EXEC   = 2'd2;

  logic [1:0]          state;
  logic [ROM_ADDR-1:0] pc;

  assign rom_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      pc    <= '0;
      issue <= 1'b0;
    end else begin
      issue <= 1'b0;
      case (state)
        S_IDLE: begin
          if (run && trap == TRAP_NONE) begin
            issue <= 1'b1;
            state <= S_DECODE;
          end
        end
        // Length is known once decode has seen the immediate
        S_DECODE: begin
          if (dec_valid) begin
            pc    <= pc + ROM_ADDR'(instr_len);
            state <= S_EXEC;
          end
        end
        // Next instruction needs the settled stack
        S_EXEC: begin
          if (exec_done) begin
            if (run && trap == TRAP_NONE) begin
              issue <= 1'b1;
              state <= S_DECODE;
            end else begin
              state <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  a_no_issue_on_trap: assert property (@(posedge clk) disable iff (reset)
    issue |-> trap == TRAP_NONE);

endmodule

//--- source/operand_stack.sv
`timescale 1ns/1ps

module operand_stack import wasm_pkg::*; #(
  parameter int STACK_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  stack_op_e            op,
  input  stack_entry_t         data,
  output stack_entry_t         tos,
  output stack_entry_t         nos,
  output stack_entry_t         third,
  output logic [STACK_DEPTH:0] depth,
  output logic                 empty,
  output logic                 overflow
);

  localparam int                   ENTRIES = 2 ** STACK_DEPTH;
  localparam logic [STACK_DEPTH:0] FULL    = (STACK_DEPTH + 1)'(ENTRIES);

  stack_entry_t           mem [ENTRIES];
  logic [STACK_DEPTH:0]   sp;
  logic [STACK_DEPTH-1:0] tos_idx;
  logic [STACK_DEPTH-1:0] nos_idx;
  logic [STACK_DEPTH-1:0] third_idx;

  // Entries consumed by each command
  function automatic int pops_of(stack_op_e cmd);
    case (cmd)
      STK_POP, STK_REPLACE: return 1;
      STK_POP2_PUSH:        return 2;
      STK_POP3_PUSH:        return 3;
      default:              return 0;
    endcase
  endfunction

  // sp counts entries, top sits one below it
  assign tos_idx   = STACK_DEPTH'(sp - 1);
  assign nos_idx   = STACK_DEPTH'(sp - 2);
  assign third_idx = STACK_DEPTH'(sp - 3);

  assign tos   = mem[tos_idx];
  assign nos   = mem[nos_idx];
  assign third = mem[third_idx];
  assign depth = sp;
  assign empty = (sp == '0);

  always_ff @(posedge clk) begin
    case (op)
      STK_PUSH:      if (sp != FULL) mem[sp[STACK_DEPTH-1:0]] <= data;
      STK_REPLACE:   mem[tos_idx]   <= data;
      STK_POP2_PUSH: mem[nos_idx]   <= data;
      STK_POP3_PUSH: mem[third_idx] <= data;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sp       <= '0;
      overflow <= 1'b0;
    end else begin
      case (op)
        STK_PUSH: begin
          if (sp == FULL) overflow <= 1'b1;
          else            sp       <= sp + 1'b1;
        end
        STK_POP, STK_POP2_PUSH: sp <= sp - 1'b1;
        STK_POP3_PUSH:          sp <= sp - 2'd2;
        default: ;
      endcase
    end
  end

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pops_of(op) > 0 |-> int'(sp) >= pops_of(op));

endmodule

//--- source/program_rom.sv
`timescale 1ns/1ps

module program_rom import wasm_pkg::*; #(
  parameter int ROM_ADDR = 8
) (
  input  logic                      clk,
  input  logic                      we,
  input  logic [ROM_ADDR-1:0]       waddr,
  input  logic [7:0]                wdata,
  input  logic [ROM_ADDR-1:0]       raddr,
  output logic [WINDOW_BYTES*8-1:0] window
);

  localparam int ROM_SIZE = 2 ** ROM_ADDR;

  logic [7:0] mem [ROM_SIZE];

  // Program load port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Byte at raddr lands in the top byte of the window
  // and the address wraps at the end of memory
  always_ff @(posedge clk) begin
    for (int i = 0; i < WINDOW_BYTES; i++) begin
      window[(WINDOW_BYTES-1-i)*8 +: 8] <= mem[ROM_ADDR'(raddr + ROM_ADDR'(i))];
    end
  end

endmodule

//--- source/wasm_core.sv
`timescale 1ns/1ps

module wasm_core import wasm_pkg::*; #(
  parameter int ROM_ADDR    = 8,
  parameter int STACK_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic                prog_we,
  input  logic [ROM_ADDR-1:0] prog_addr,
  input  logic [7:0]          prog_data,
  output logic [VALUE_W-1:0]  result,
  output val_type_t           result_type,
  output logic                result_empty,
  output trap_e               trap
);

  logic [ROM_ADDR-1:0]       rom_addr;
  logic                      issue;
  logic [WINDOW_BYTES*8-1:0] rom_window;
  logic                      dec_valid;
  opcode_e                   opcode;
  logic [VALUE_W-1:0]        imm;
  logic [LEN_W-1:0]          instr_len;
  stack_op_e                 stk_op;
  stack_entry_t              stk_data;
  logic                      exec_done;
  stack_entry_t              tos;
  stack_entry_t              nos;
  stack_entry_t              third;
  logic [STACK_DEPTH:0]      depth;
  logic                      empty;
  logic                      overflow;

  // Top of stack is the visible result
  assign result       = tos.value.i64;
  assign result_type  = tos.vtype;
  assign result_empty = empty;

  program_rom #(.ROM_ADDR(ROM_ADDR)) program_rom_i (
    .clk(clk), .we(prog_we), .waddr(prog_addr), .wdata(prog_data),
    .raddr(rom_addr), .window(rom_window)
  );

  fetch_stage #(.ROM_ADDR(ROM_ADDR)) fetch_stage_i (
    .clk(clk), .reset(reset), .run(run), .dec_valid(dec_valid),
    .instr_len(instr_len), .exec_done(exec_done), .trap(trap),
    .rom_addr(rom_addr), .issue(issue)
  );

  decode_stage decode_stage_i (
    .clk(clk), .reset(reset), .issue(issue), .rom_window(rom_window),
    .dec_valid(dec_valid), .opcode(opcode), .imm(imm), .instr_len(instr_len)
  );

  execute_stage #(.STACK_DEPTH(STACK_DEPTH)) execute_stage_i (
    .clk(clk), .reset(reset), .dec_valid(dec_valid), .opcode(opcode), .imm(imm),
    .tos(tos), .nos(nos), .third(third), .empty(empty), .depth(depth),
    .overflow(overflow), .stk_op(stk_op), .stk_data(stk_data),
    .exec_done(exec_done), .trap(trap)
  );

  operand_stack #(.STACK_DEPTH(STACK_DEPTH)) operand_stack_i (
    .clk(clk), .reset(reset), .op(stk_op), .data(stk_data),
    .tos(tos), .nos(nos), .third(third), .depth(depth),
    .empty(empty), .overflow(overflow)
  );

endmodule

//--- source/wasm_pkg.sv
package wasm_pkg;

  // Datapath sizes
  localparam int VALUE_W      = 64;
  localparam int IMM_BYTES    = 10;
  localparam int WINDOW_BYTES = IMM_BYTES + 1;
  localparam int LEN_W        = $clog2(WINDOW_BYTES + 1);

  // Encoded as 0x7f minus the wasm value type byte
  typedef enum logic [1:0] {
    TYPE_I32 = 2'd0,
    TYPE_I64 = 2'd1,
    TYPE_F32 = 2'd2,
    TYPE_F64 = 2'd3
  } val_type_t;

  // Same word seen as one i64 or as two i32 halves
  typedef union packed {
    logic [VALUE_W-1:0] i64;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } i32;
  } value_u;

  typedef struct packed {
    val_type_t vtype;
    value_u    value;
  } stack_entry_t;

  typedef enum logic [7:0] {
    OP_UNREACHABLE = 8'h00,
    OP_NOP         = 8'h01,
    OP_END         = 8'h0b,
    OP_DROP        = 8'h1a,
    OP_SELECT      = 8'h1b,
    OP_I32_CONST   = 8'h41,
    OP_I64_CONST   = 8'h42,
    OP_I32_EQZ     = 8'h45,
    OP_I32_EQ      = 8'h46,
    OP_I32_NE      = 8'h47,
    OP_I64_EQZ     = 8'h50,
    OP_I64_EQ      = 8'h51,
    OP_I64_NE      = 8'h52,
    OP_I32_ADD     = 8'h6a,
    OP_I32_SUB     = 8'h6b,
    OP_I64_ADD     = 8'h7c,
    OP_I64_SUB     = 8'h7d
  } opcode_e;

  typedef enum logic [3:0] {
    TRAP_NONE           = 4'd0,
    TRAP_ENDED          = 4'd1,
    TRAP_UNREACHABLE    = 4'd2,
    TRAP_STACK_EMPTY    = 4'd3,
    TRAP_STACK_ERROR    = 4'd4,
    TRAP_TYPE_MISMATCH  = 4'd5,
    TRAP_TYPES_MISMATCH = 4'd6,
    TRAP_UNKNOWN_OPCODE = 4'd7
  } trap_e;

  // POP3_PUSH is the select case: three entries collapse into one
  typedef enum logic [2:0] {
    STK_NONE      = 3'd0,
    STK_PUSH      = 3'd1,
    STK_POP       = 3'd2,
    STK_REPLACE   = 3'd3,
    STK_POP2_PUSH = 3'd4,
    STK_POP3_PUSH = 3'd5
  } stack_op_e;

endpackage
